/* hdmiVideo_macros.svh */
/*
 * HDMI video transmitter constants
 * 720x480p raster counts, Neo Geo picture window, encoder pipeline depth,
 * preamble and guard band lengths, colour word layout and TMDS codes
 */
`ifndef HDMIVIDEO_MACROS_SVH
`define HDMIVIDEO_MACROS_SVH

////////////////////////////////////////
// Raster counts for 720x480p
////////////////////////////////////////
`define H_ACTIVE 720
`define H_TOTAL 858
`define H_FRONT 16
`define H_SYNC 62
`define V_ACTIVE 480
`define V_TOTAL 525
`define V_FRONT 9
`define V_SYNC 6

// Neo Geo picture is 640 wide, centred in the 720 active pixels
`define NEO_WIDTH 640
`define CENTER_X 40

// Pipeline depth of the TMDS encoder
`define ENC_DELAY 2

// Video preamble and leading guard band, both at the end of each line
`define PREAMBLE_LEN 8
`define GUARD_LEN 2

////////////////////////////////////////
// Neo Geo 17-bit colour word
////////////////////////////////////////
`define NEO_RED_LSB 0
`define NEO_GREEN_LSB 5
`define NEO_BLUE_LSB 10
// Shared low bit, appended under every 5-bit field
`define NEO_LOW_BIT 15
// Full brightness, clear means shadowed
`define NEO_FULL_BIT 16

// Video guard band symbols
`define GUARD_RB 10'b1011001100
`define GUARD_G 10'b0100110011

// Control period tokens, indexed by {C1, C0}
`define CTRL_TOKEN0 10'b1101010100
`define CTRL_TOKEN1 10'b0010101011
`define CTRL_TOKEN2 10'b0101010100
`define CTRL_TOKEN3 10'b1010101011

`endif

/* hdmiVideoPkg.sv */
/*
 * HDMI video types
 * TMDS channel symbol with raw and video views, and the scanline
 * effect selection shared by the raster generator and the shader
 */
package hdmiVideoPkg;

	////////////////////////////////////////
	// TMDS channel symbol
	////////////////////////////////////////

	// Raw view carries control tokens and guard bands as whole codes
	// Video view splits a DC-balanced video word into its fields
	typedef union packed {
		logic [9:0] raw;
		struct packed {
			// Payload sent inverted to pull the running disparity back
			logic       dcInvert;
			// Set when the XOR chain was used, clear for XNOR
			logic       xnorMode;
			logic [7:0] payload;
		} video;
	} tmdsSymbol_u;

	////////////////////////////////////////
	// Scanline effects
	////////////////////////////////////////

	// Bit 0 swaps the dimmed line parity every frame
	// Bit 1 blanks the dimmed lines instead of halving them
	typedef enum logic [2:0] {
		scanHalfOdd  = 3'd0,
		scanHalfAlt  = 3'd1,
		scanBlackOdd = 3'd2,
		scanBlackAlt = 3'd3,
		// Every line at full brightness
		scanDouble   = 3'd4
	} scanMode_e;

endpackage

/* rasterTiming.sv */
/*
 * Raster generator
 * Free-running 858x525 pixel and line counters, active-low syncs,
 * active video area, centred Neo Geo pixel requests and the
 * per-frame scanline parity
 */
`timescale 1ns/1ps
`include "hdmiVideo_macros.svh"

module rasterTiming import hdmiVideoPkg::*; (
	input  logic       pixclk,
	input  logic       rstN,
	input  scanMode_e  scanMode,
	output logic [9:0] counterX,
	output logic [9:0] counterY,
	output logic       hSync,
	output logic       vSync,
	output logic       drawArea,
	output logic [9:0] pixelX,
	output logic [8:0] pixelY,
	output logic       pixelValid,
	output logic       showLine
);
	localparam logic [9:0] LAST_X = 10'(`H_TOTAL - 1);
	localparam logic [9:0] LAST_Y = 10'(`V_TOTAL - 1);
	localparam logic [9:0] H_ACT = 10'(`H_ACTIVE);
	localparam logic [9:0] V_ACT = 10'(`V_ACTIVE);
	localparam logic [9:0] HS_START = 10'(`H_ACTIVE + `H_FRONT);
	localparam logic [9:0] HS_END = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	// vSync switches on the line before, at the hSync start position
	localparam logic [9:0] VS_START = 10'(`V_ACTIVE + `V_FRONT - 1);
	localparam logic [9:0] VS_END = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1);
	localparam logic [9:0] WIN_START = 10'(`CENTER_X);
	localparam logic [9:0] WIN_END = 10'(`CENTER_X + `NEO_WIDTH);

	logic [9:0] nextX;
	logic [9:0] nextY;
	logic       lineEnd;
	logic       frameEnd;
	scanMode_e  modeLatch;
	scanMode_e  nextMode;
	logic       frameParity;
	logic       nextParity;
	logic       inWindow;
	logic       vsActive;

	////////////////////////////////////////
	// Counter lookahead
	////////////////////////////////////////
	always_comb begin
		lineEnd = (counterX == LAST_X);
		frameEnd = lineEnd && (counterY == LAST_Y);
		nextX = lineEnd ? 10'd0 : counterX + 10'd1;
		nextY = lineEnd ? (frameEnd ? 10'd0 : counterY + 10'd1) : counterY;
		// Mode and parity that the next position belongs to
		nextMode = frameEnd ? scanMode : modeLatch;
		nextParity = (frameEnd && scanMode[0]) ? ~frameParity : frameParity;
		// Request window is judged one pixel ahead
		// so the shaded colour lines up with drawArea
		inWindow = (nextX >= WIN_START) && (nextX < WIN_END) && (nextY < V_ACT);
		vsActive = ((counterY > VS_START) || (counterY == VS_START && counterX >= HS_START))
			&& ((counterY < VS_END) || (counterY == VS_END && counterX < HS_START));
	end

	always_ff @(posedge pixclk or negedge rstN) begin
		if (!rstN) begin
			counterX <= '0;
			counterY <= '0;
			modeLatch <= scanDouble;
			frameParity <= 1'b0;
			hSync <= 1'b1;
			vSync <= 1'b1;
			drawArea <= 1'b0;
			pixelX <= '0;
			pixelY <= '0;
			pixelValid <= 1'b0;
			showLine <= 1'b0;
		end else begin
			counterX <= nextX;
			counterY <= nextY;
			modeLatch <= nextMode;
			frameParity <= nextParity;
			// Syncs and area follow the current count
			hSync <= !((counterX >= HS_START) && (counterX < HS_END));
			vSync <= !vsActive;
			drawArea <= (counterX < H_ACT) && (counterY < V_ACT);
			// Request for the next count
			pixelX <= inWindow ? nextX - WIN_START : '0;
			pixelY <= inWindow ? nextY[8:0] : '0;
			pixelValid <= inWindow;
			// Full line when parity matches the frame, or plain doubling
			showLine <= (nextY[0] == nextParity) || (nextMode == scanDouble);
		end
	end

endmodule

/* scanlineShader.sv */
/*
 * Scanline shader
 * Expands the Neo Geo 17-bit colour word to 8 bits per channel
 * and dims or blanks the lines that the scanline effect hides
 */
`timescale 1ns/1ps
`include "hdmiVideo_macros.svh"

module scanlineShader import hdmiVideoPkg::*; (
	input  logic       pixclk,
	input  logic       rstN,
	input  logic [16:0] neoPixel,
	input  logic       pixelValid,
	input  logic       showLine,
	input  scanMode_e  scanMode,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	////////////////////////////////////////
	// Colour expansion
	////////////////////////////////////////

	// 6-bit level is the 5-bit field over the shared low bit
	// Three shares when shadowed, four at full brightness, so 252 max
	function automatic logic [7:0] expandField(
		input logic [4:0] field,
		input logic       lowBit,
		input logic       fullBit
	);
		logic [7:0] level;
		level = {2'b00, field, lowBit};
		return level * 8'd3 + (fullBit ? level : 8'd0);
	endfunction

	// Hidden lines are halved, or blanked in the black modes
	function automatic logic [7:0] dimLevel(
		input logic [7:0] level,
		input logic       show,
		input logic       blackOut
	);
		if (show) begin
			return level;
		end
		return blackOut ? 8'd0 : {1'b0, level[7:1]};
	endfunction

	logic [7:0] redFull;
	logic [7:0] greenFull;
	logic [7:0] blueFull;

	assign redFull = expandField(neoPixel[`NEO_RED_LSB +: 5],
		neoPixel[`NEO_LOW_BIT], neoPixel[`NEO_FULL_BIT]);
	assign greenFull = expandField(neoPixel[`NEO_GREEN_LSB +: 5],
		neoPixel[`NEO_LOW_BIT], neoPixel[`NEO_FULL_BIT]);
	assign blueFull = expandField(neoPixel[`NEO_BLUE_LSB +: 5],
		neoPixel[`NEO_LOW_BIT], neoPixel[`NEO_FULL_BIT]);

	// One register stage, border pixels are black
	always_ff @(posedge pixclk or negedge rstN) begin
		if (!rstN) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else if (!pixelValid) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			red <= dimLevel(redFull, showLine, scanMode[1]);
			green <= dimLevel(greenFull, showLine, scanMode[1]);
			blue <= dimLevel(blueFull, showLine, scanMode[1]);
		end
	end

endmodule

/* tmdsEncoder.sv */
/*
 * TMDS video encoder
 * Stage one picks XOR or XNOR transition minimisation.
 * Stage two tracks running disparity, inverts words to balance it
 * and sends a control token whenever video is off
 */
`timescale 1ns/1ps
`include "hdmiVideo_macros.svh"

module tmdsEncoder import hdmiVideoPkg::*; (
	input  logic        pixclk,
	input  logic        rstN,
	input  logic [7:0]  videoData,
	input  logic [1:0]  ctrlData,
	input  logic        videoEnable,
	output tmdsSymbol_u symbol
);
	logic [3:0]        dataOnes;
	logic              useXnor;
	logic [8:0]        qmNext;
	logic [8:0]        qm;
	logic [1:0]        ctrlReg;
	logic              enableReg;
	logic [3:0]        qmOnes;
	// Ones minus zeros of the stage-one word
	logic signed [5:0] qmBalance;
	logic signed [5:0] disparity;
	logic              invertWord;

	////////////////////////////////////////
	// Stage one
	////////////////////////////////////////
	always_comb begin
		dataOnes = 4'($countones(videoData));
		useXnor = (dataOnes > 4'd4) || (dataOnes == 4'd4 && !videoData[0]);
		qmNext[0] = videoData[0];
		for (int i = 1; i < 8; i++) begin
			qmNext[i] = useXnor ? ~(qmNext[i-1] ^ videoData[i]) : qmNext[i-1] ^ videoData[i];
		end
		qmNext[8] = ~useXnor;
	end

	always_ff @(posedge pixclk) begin
		qm <= qmNext;
		ctrlReg <= ctrlData;
	end

	////////////////////////////////////////
	// Stage two
	////////////////////////////////////////
	always_comb begin
		qmOnes = 4'($countones(qm[7:0]));
		qmBalance = signed'({1'b0, qmOnes, 1'b0}) - 6'sd8;
		// Neutral case follows the chain type, else push against the sign
		if (disparity == 6'sd0 || qmBalance == 6'sd0)
			invertWord = !qm[8];
		else
			invertWord = (disparity[5] == qmBalance[5]);
	end

	always_ff @(posedge pixclk or negedge rstN) begin
		if (!rstN) begin
			enableReg <= 1'b0;
			disparity <= '0;
		end else begin
			enableReg <= videoEnable;
			if (!enableReg)
				disparity <= '0;
			else if (disparity == 6'sd0 || qmBalance == 6'sd0)
				disparity <= invertWord ? disparity - qmBalance : disparity + qmBalance;
			else if (invertWord)
				disparity <= disparity + (qm[8] ? 6'sd2 : 6'sd0) - qmBalance;
			else
				disparity <= disparity - (qm[8] ? 6'sd0 : 6'sd2) + qmBalance;
		end
	end

	always_ff @(posedge pixclk) begin
		if (enableReg) begin
			symbol.video.dcInvert <= invertWord;
			symbol.video.xnorMode <= qm[8];
			symbol.video.payload <= invertWord ? ~qm[7:0] : qm[7:0];
		end else begin
			case (ctrlReg)
				2'b00: symbol.raw <= `CTRL_TOKEN0;
				2'b01: symbol.raw <= `CTRL_TOKEN1;
				2'b10: symbol.raw <= `CTRL_TOKEN2;
				default: symbol.raw <= `CTRL_TOKEN3;
			endcase
		end
	end

endmodule

/* periodSequencer.sv */
/*
 * Video period sequencer
 * Drives the video preamble control codes at the end of each line
 * and swaps in the guard band symbols just before active video
 */
`timescale 1ns/1ps
`include "hdmiVideo_macros.svh"

module periodSequencer import hdmiVideoPkg::*; (
	input  logic        pixclk,
	input  logic        rstN,
	input  logic [9:0]  counterX,
	input  logic        hSync,
	input  logic        vSync,
	output logic [1:0]  redCtrl,
	output logic [1:0]  greenCtrl,
	output logic [1:0]  blueCtrl,
	input  tmdsSymbol_u redIn,
	input  tmdsSymbol_u greenIn,
	input  tmdsSymbol_u blueIn,
	output tmdsSymbol_u tmdsRed,
	output tmdsSymbol_u tmdsGreen,
	output tmdsSymbol_u tmdsBlue
);
	localparam logic [9:0] PREAMBLE_START = 10'(`H_TOTAL - `PREAMBLE_LEN - `GUARD_LEN);
	localparam logic [9:0] GUARD_START = 10'(`H_TOTAL - `GUARD_LEN);

	logic                  preamble;
	logic                  guardBand;
	// Guard flag travelling alongside the encoder stages
	logic [`ENC_DELAY-1:0] guardPipe;

	////////////////////////////////////////
	// Period timing
	////////////////////////////////////////
	always_ff @(posedge pixclk or negedge rstN) begin
		if (!rstN) begin
			preamble <= 1'b0;
			guardBand <= 1'b0;
			guardPipe <= '0;
		end else begin
			// Registered once, in step with the syncs
			preamble <= (counterX >= PREAMBLE_START) && (counterX < GUARD_START);
			guardBand <= (counterX >= GUARD_START);
			guardPipe <= {guardPipe[`ENC_DELAY-2:0], guardBand};
		end
	end

	// Video preamble is CTL0 high, CTL1 to CTL3 low
	assign redCtrl = 2'b00;
	assign greenCtrl = {1'b0, preamble};
	assign blueCtrl = {vSync, hSync};

	// Output register, guard band overrides the encoded symbols
	always_ff @(posedge pixclk or negedge rstN) begin
		if (!rstN) begin
			tmdsRed.raw <= `CTRL_TOKEN0;
			tmdsGreen.raw <= `CTRL_TOKEN0;
			// Both syncs inactive
			tmdsBlue.raw <= `CTRL_TOKEN3;
		end else if (guardPipe[`ENC_DELAY-1]) begin
			tmdsRed.raw <= `GUARD_RB;
			tmdsGreen.raw <= `GUARD_G;
			tmdsBlue.raw <= `GUARD_RB;
		end else begin
			tmdsRed <= redIn;
			tmdsGreen <= greenIn;
			tmdsBlue <= blueIn;
		end
	end

endmodule

/* hdmiVideoTop.sv */
/*
 * HDMI video transmitter top level
 * Raster generator, scanline shader, one TMDS encoder per channel
 * and the period sequencer on the output side
 */
`timescale 1ns/1ps

module hdmiVideoTop import hdmiVideoPkg::*; (
	input  logic        pixclk,
	input  logic        rstN,
	input  logic [16:0] neoPixel,
	input  scanMode_e   scanMode,
	output logic [9:0]  pixelX,
	output logic [8:0]  pixelY,
	output logic        pixelValid,
	output tmdsSymbol_u tmdsRed,
	output tmdsSymbol_u tmdsGreen,
	output tmdsSymbol_u tmdsBlue
);
	logic [9:0]  counterX;
	logic        hSync;
	logic        vSync;
	logic        drawArea;
	logic        showLine;
	logic [7:0]  red;
	logic [7:0]  green;
	logic [7:0]  blue;
	logic [1:0]  redCtrl;
	logic [1:0]  greenCtrl;
	logic [1:0]  blueCtrl;
	tmdsSymbol_u encRedSym;
	tmdsSymbol_u encGreenSym;
	tmdsSymbol_u encBlueSym;

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////
	// The sequencer needs only the pixel count
	rasterTiming raster (
		.pixclk(pixclk), .rstN(rstN), .scanMode(scanMode),
		.counterX(counterX), .counterY(),
		.hSync(hSync), .vSync(vSync), .drawArea(drawArea),
		.pixelX(pixelX), .pixelY(pixelY), .pixelValid(pixelValid),
		.showLine(showLine)
	);

	////////////////////////////////////////
	// Processing
	////////////////////////////////////////
	scanlineShader shader (
		.pixclk(pixclk), .rstN(rstN), .neoPixel(neoPixel),
		.pixelValid(pixelValid), .showLine(showLine), .scanMode(scanMode),
		.red(red), .green(green), .blue(blue)
	);

	tmdsEncoder encRed (
		.pixclk(pixclk), .rstN(rstN), .videoData(red), .ctrlData(redCtrl),
		.videoEnable(drawArea), .symbol(encRedSym)
	);
	tmdsEncoder encGreen (
		.pixclk(pixclk), .rstN(rstN), .videoData(green), .ctrlData(greenCtrl),
		.videoEnable(drawArea), .symbol(encGreenSym)
	);
	// Blue control carries the syncs
	tmdsEncoder encBlue (
		.pixclk(pixclk), .rstN(rstN), .videoData(blue), .ctrlData(blueCtrl),
		.videoEnable(drawArea), .symbol(encBlueSym)
	);

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////
	periodSequencer sequencer (
		.pixclk(pixclk), .rstN(rstN), .counterX(counterX),
		.hSync(hSync), .vSync(vSync),
		.redCtrl(redCtrl), .greenCtrl(greenCtrl), .blueCtrl(blueCtrl),
		.redIn(encRedSym), .greenIn(encGreenSym), .blueIn(encBlueSym),
		.tmdsRed(tmdsRed), .tmdsGreen(tmdsGreen), .tmdsBlue(tmdsBlue)
	);

endmodule

/* hdmiVideo_properties.sv */
/*
 * Period sequencer assertions
 * Guard band length, the preamble in front of it,
 * and steady sync bits on blue while the guard band runs
 */
`timescale 1ns/1ps
`include "hdmiVideo_macros.svh"

module sequencerProperties (
	input logic       pixclk,
	input logic       rstN,
	input logic       preamble,
	input logic       guardBand,
	input logic [1:0] blueCtrl
);
	// Length of the current run of preamble cycles
	logic [3:0] preambleRun;

	always_ff @(posedge pixclk or negedge rstN) begin
		if (!rstN)
			preambleRun <= '0;
		else
			preambleRun <= preamble ? preambleRun + 4'd1 : 4'd0;
	end

	////////////////////////////////////////
	// Guard band rules
	////////////////////////////////////////
	guardHolds: assert property (@(posedge pixclk) disable iff (!rstN)
		$rose(guardBand) |=> guardBand)
		else $error("guard band shorter than two cycles");

	guardEnds: assert property (@(posedge pixclk) disable iff (!rstN)
		guardBand && $past(guardBand) |=> !guardBand)
		else $error("guard band longer than two cycles");

	// Full preamble right before the guard band
	preambleLeads: assert property (@(posedge pixclk) disable iff (!rstN)
		$rose(guardBand) |-> preambleRun == 4'(`PREAMBLE_LEN))
		else $error("guard band not preceded by a full preamble");

	syncSteady: assert property (@(posedge pixclk) disable iff (!rstN)
		guardBand && $past(guardBand) |-> $stable(blueCtrl))
		else $error("sync bits changed during the guard band");

endmodule

bind periodSequencer sequencerProperties props (
	.pixclk(pixclk), .rstN(rstN), .preamble(preamble),
	.guardBand(guardBand), .blueCtrl(blueCtrl)
);

/* hdmiVideoTb.sv */
/*
 * HDMI video transmitter testbench
 * Answers pixel requests with salted colour words, keeps its own raster
 * and scanline model, decodes the TMDS symbols and checks colours,
 * control tokens, guard bands and sync levels on every cycle
 */
`timescale 1ns/1ps
`include "hdmiVideo_macros.svh"

module hdmiVideoTb import hdmiVideoPkg::*; ();
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int PIPE_DELAY = 4;
	// Partial first frame, 1 doubling, 2 static, 4 alternating
	localparam int TEST_FRAMES = 8;
	localparam int WATCHDOG_NS = (TEST_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD;
	// Mode changes land in vertical blanking, line 500
	localparam int MODE_SWITCH_POS = 500 * `H_TOTAL;
	localparam int HS_START = `H_ACTIVE + `H_FRONT;
	localparam int PREAMBLE_START = `H_TOTAL - `PREAMBLE_LEN - `GUARD_LEN;
	localparam int PRINT_LIMIT = 20;

	logic        pixclk;
	logic        rstN;
	logic [16:0] neoPixel;
	scanMode_e   scanMode;
	logic [9:0]  pixelX;
	logic [8:0]  pixelY;
	logic        pixelValid;
	tmdsSymbol_u tmdsRed;
	tmdsSymbol_u tmdsGreen;
	tmdsSymbol_u tmdsBlue;

	// Model state
	int          cycle = 0;
	scanMode_e   latchedMode = scanDouble;
	logic        frameParity = 1'b0;
	logic [31:0] salt;
	logic [23:0] expectedRing [8];
	string       curTest;
	int          colourErrors = 0;
	int          symbolErrors = 0;
	int          syncErrors = 0;
	int          coordErrors = 0;

	hdmiVideoTop hdmiVideoTop_i (
		.pixclk(pixclk), .rstN(rstN), .neoPixel(neoPixel), .scanMode(scanMode),
		.pixelX(pixelX), .pixelY(pixelY), .pixelValid(pixelValid),
		.tmdsRed(tmdsRed), .tmdsGreen(tmdsGreen), .tmdsBlue(tmdsBlue)
	);

	initial begin
		pixclk = 1'b0;
		forever #(CLK_PERIOD / 2) pixclk = ~pixclk;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// 6-bit level times three, one more share at full brightness
	function automatic logic [7:0] shadeChannel(input int field, input bit lowBit,
		input bit fullBit, input bit show, input bit black);
		int level;
		int value;
		level = field * 2 + int'(lowBit);
		value = 3 * level;
		if (fullBit)
			value += level;
		if (!show)
			value = black ? 0 : value / 2;
		return 8'(value);
	endfunction

	// Undo DC inversion, then the XOR or XNOR chain
	function automatic logic [7:0] decodeVideo(input tmdsSymbol_u sym);
		logic [7:0] q;
		logic [7:0] d;
		q = sym.video.dcInvert ? ~sym.video.payload : sym.video.payload;
		d[0] = q[0];
		for (int i = 1; i < 8; i++) begin
			d[i] = sym.video.xnorMode ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		end
		return d;
	endfunction

	// Returns {valid, vSync, hSync}
	function automatic logic [2:0] tokenSyncs(input tmdsSymbol_u sym);
		case (sym.raw)
			`CTRL_TOKEN0: return 3'b100;
			`CTRL_TOKEN1: return 3'b101;
			`CTRL_TOKEN2: return 3'b110;
			`CTRL_TOKEN3: return 3'b111;
			default: return 3'b000;
		endcase
	endfunction

	function automatic tmdsSymbol_u toSymbol(input logic [9:0] code);
		tmdsSymbol_u sym;
		sym.raw = code;
		return sym;
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic checkColour(input string testName, input string what,
		input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			colourErrors++;
			if (colourErrors <= PRINT_LIMIT)
				$display("[ERROR] %s %s at %0t expected %0d actual %0d",
					testName, what, $time, expected, actual);
		end
	endtask

	task automatic checkSymbol(input string testName, input string what,
		input tmdsSymbol_u expected, input tmdsSymbol_u actual);
		if (actual.raw !== expected.raw) begin
			symbolErrors++;
			if (symbolErrors <= PRINT_LIMIT)
				$display("[ERROR] %s %s at %0t expected %b actual %b",
					testName, what, $time, expected.raw, actual.raw);
		end
	endtask

	task automatic checkLevel(input string testName, input string what,
		input logic expected, input logic actual);
		if (actual !== expected) begin
			syncErrors++;
			if (syncErrors <= PRINT_LIMIT)
				$display("[ERROR] %s %s at %0t expected %b actual %b",
					testName, what, $time, expected, actual);
		end
	endtask

	task automatic checkCoord(input string testName, input string what,
		input logic [9:0] expected, input logic [9:0] actual);
		if (actual !== expected) begin
			coordErrors++;
			if (coordErrors <= PRINT_LIMIT)
				$display("[ERROR] %s %s at %0t expected %0d actual %0d",
					testName, what, $time, expected, actual);
		end
	endtask

	// Symbols for raster position p, four cycles behind the request
	task automatic checkOutputs(input int p);
		int x;
		int y;
		int ys;
		logic [23:0] colour;
		logic [2:0] syncs;
		x = (p % FRAME_CYCLES) % `H_TOTAL;
		y = (p % FRAME_CYCLES) / `H_TOTAL;
		// vSync is counted in lines that start at the hSync position
		ys = (x >= HS_START) ? y : y - 1;
		if (x < `H_ACTIVE && y < `V_ACTIVE) begin
			colour = expectedRing[3'(p)];
			checkColour(curTest, "red", colour[23:16], decodeVideo(tmdsRed));
			checkColour(curTest, "green", colour[15:8], decodeVideo(tmdsGreen));
			checkColour(curTest, "blue", colour[7:0], decodeVideo(tmdsBlue));
		end else if (x >= `H_TOTAL - `GUARD_LEN) begin
			checkSymbol(curTest, "red guard", toSymbol(`GUARD_RB), tmdsRed);
			checkSymbol(curTest, "green guard", toSymbol(`GUARD_G), tmdsGreen);
			checkSymbol(curTest, "blue guard", toSymbol(`GUARD_RB), tmdsBlue);
		end else begin
			checkSymbol(curTest, "red token", toSymbol(`CTRL_TOKEN0), tmdsRed);
			// Preamble raises CTL0 on green
			checkSymbol(curTest, "green token",
				toSymbol(x >= PREAMBLE_START ? `CTRL_TOKEN1 : `CTRL_TOKEN0), tmdsGreen);
			syncs = tokenSyncs(tmdsBlue);
			if (!syncs[2]) begin
				syncErrors++;
				$display("%s: blue channel at line %0d pixel %0d carries no control token",
					curTest, y, x);
			end else begin
				checkLevel(curTest, "hSync", !(x >= HS_START && x < HS_START + `H_SYNC),
					syncs[0]);
				checkLevel(curTest, "vSync",
					!(ys >= `V_ACTIVE + `V_FRONT - 1 && ys < `V_ACTIVE + `V_FRONT + `V_SYNC - 1),
					syncs[1]);
			end
		end
	endtask

	////////////////////////////////////////
	// Per-cycle stimulus and model
	////////////////////////////////////////
	task automatic stepCycle();
		int pos;
		int x;
		int y;
		bit inWin;
		bit show;
		bit black;
		@(negedge pixclk);
		cycle++;
		if (cycle >= PIPE_DELAY)
			checkOutputs(cycle - PIPE_DELAY);
		pos = cycle % FRAME_CYCLES;
		x = pos % `H_TOTAL;
		y = pos / `H_TOTAL;
		// Frame start latches the mode and may swap the parity
		if (pos == 0) begin
			latchedMode = scanMode;
			if (scanMode[0])
				frameParity = !frameParity;
		end
		inWin = (y < `V_ACTIVE) && (x >= `CENTER_X) && (x < `CENTER_X + `NEO_WIDTH);
		checkLevel(curTest, "pixelValid", inWin, pixelValid);
		// Source column is offset by the border, source row is the display line
		checkCoord(curTest, "pixelX", inWin ? 10'(x - `CENTER_X) : 10'd0, pixelX);
		checkCoord(curTest, "pixelY", inWin ? 10'(y) : 10'd0, {1'b0, pixelY});
		// Pixel responder
		salt = xorshift(salt);
		neoPixel = 17'({pixelY, pixelX}) ^ salt[16:0];
		show = (y[0] == frameParity) || (latchedMode == scanDouble);
		black = scanMode[1];
		if (inWin)
			expectedRing[3'(cycle)] = {
				shadeChannel(int'(neoPixel[`NEO_RED_LSB +: 5]), neoPixel[`NEO_LOW_BIT],
					neoPixel[`NEO_FULL_BIT], show, black),
				shadeChannel(int'(neoPixel[`NEO_GREEN_LSB +: 5]), neoPixel[`NEO_LOW_BIT],
					neoPixel[`NEO_FULL_BIT], show, black),
				shadeChannel(int'(neoPixel[`NEO_BLUE_LSB +: 5]), neoPixel[`NEO_LOW_BIT],
					neoPixel[`NEO_FULL_BIT], show, black)};
		else
			expectedRing[3'(cycle)] = '0;
	endtask

	// Switch mode in blanking, then run whole frames in it
	task automatic runFrames(input string name, input scanMode_e mode, input int frames);
		curTest = name;
		while ((cycle % FRAME_CYCLES) != MODE_SWITCH_POS)
			stepCycle();
		scanMode = mode;
		repeat (frames * FRAME_CYCLES) stepCycle();
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic testReset();
		curTest = "resetState";
		checkSymbol(curTest, "red", toSymbol(`CTRL_TOKEN0), tmdsRed);
		checkSymbol(curTest, "green", toSymbol(`CTRL_TOKEN0), tmdsGreen);
		// Both syncs inactive
		checkSymbol(curTest, "blue", toSymbol(`CTRL_TOKEN3), tmdsBlue);
	endtask

	task automatic testColourExpansion();
		runFrames("colourExpansion", scanDouble, 1);
	endtask

	task automatic testStaticScanlines();
		runFrames("halfOdd", scanHalfOdd, 1);
		runFrames("blackOdd", scanBlackOdd, 1);
	endtask

	// Two frames each, so the dimmed parity is seen both ways
	task automatic testAlternatingScanlines();
		runFrames("halfAlt", scanHalfAlt, 2);
		runFrames("blackAlt", scanBlackAlt, 2);
	endtask

	initial begin
		int totalErrors;
		rstN = 1'b0;
		neoPixel = '0;
		scanMode = scanDouble;
		salt = 32'd57902;
		for (int i = 0; i < 8; i++) begin
			expectedRing[i] = '0;
		end
		repeat (RESET_CYCLES) @(negedge pixclk);
		testReset();
		rstN = 1'b1;
		testColourExpansion();
		testStaticScanlines();
		testAlternatingScanlines();
		totalErrors = colourErrors + symbolErrors + syncErrors + coordErrors;
		$display("Errors: colour %0d, symbol %0d, sync %0d, coordinate %0d", colourErrors,
			symbolErrors, syncErrors, coordErrors);
		if (totalErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d frames", TEST_FRAMES + 1);
		$display("Test failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
hdmiVideoPkg.sv
rasterTiming.sv
scanlineShader.sv
tmdsEncoder.sv
periodSequencer.sv
hdmiVideoTop.sv
hdmiVideo_properties.sv
hdmiVideoTb.sv

/* Makefile */
# Verilator build and run for the HDMI video testbench

VERILATOR  ?= verilator
TOP        ?= hdmiVideoTb
DUT_TOP    ?= hdmiVideoTop
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only
RTL_SRCS   ?= hdmiVideoPkg.sv rasterTiming.sv scanlineShader.sv tmdsEncoder.sv \
              periodSequencer.sv hdmiVideoTop.sv

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation result: FAIL"; exit 1; \
	else \
		echo "Simulation result: PASS"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+. --top-module $(DUT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
